// ==== hdl/pq_defs.svh ====
`ifndef PQ_DEFS_SVH
`define PQ_DEFS_SVH

// Key width in bits
`define PQ_DATA_W 32

// Number of queue slots and RAM address width
`define PQ_DEPTH 16
`define PQ_ADDR_W 4

// Element counter width
`define PQ_CNT_W 8

// All-ones key marks an unused slot
`define PQ_EMPTY_SLOT {`PQ_DATA_W{1'b1}}

`endif

// ==== hdl/pq_pkg.sv ====
package pq_pkg;

    // Router operation select
    typedef enum logic [2:0] {
        ROUTE_COMPARE    = 3'b000,
        ROUTE_COUNT_UP   = 3'b001,
        ROUTE_SHIFT      = 3'b010,
        ROUTE_COUNT_DOWN = 3'b011,
        ROUTE_IDLE       = 3'b111
    } router_mode_t;

    // Controller sequencing states
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        INS_READ,
        INS_WRITE,
        INS_COUNT,
        REM_READ,
        REM_WRITE,
        REM_COUNT
    } ctrl_state_t;

endpackage

// ==== hdl/value_router.sv ====
`timescale 1ns/100ps
`include "pq_defs.svh"

module value_router (
    input  logic [`PQ_DATA_W-1:0] bram_out,
    input  logic [`PQ_DATA_W-1:0] reg_out,
    input  pq_pkg::router_mode_t  mode,
    input  logic [`PQ_CNT_W-1:0]  array_size,
    input  logic [`PQ_CNT_W-1:0]  array_cnt_in,
    output logic [`PQ_DATA_W-1:0] bram_insert,
    output logic [`PQ_DATA_W-1:0] to_register,
    output logic [`PQ_DATA_W-1:0] data_lt_o,
    output logic [`PQ_CNT_W-1:0]  array_cnt_out,
    output logic                  result,
    output logic                  full,
    output logic                  empty
);

    import pq_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Compare, route and count
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Defaults hold in every mode
        bram_insert   = bram_out;
        to_register   = reg_out;
        data_lt_o     = '0;
        array_cnt_out = array_cnt_in;
        result        = 1'b0;

        case (mode)
            ROUTE_COMPARE: begin
                // Carried key wins on strictly greater, or on an empty slot
                result = (reg_out > bram_out) || (bram_out == `PQ_EMPTY_SLOT);
                if (result) begin
                    // Swap: larger key stays in the slot
                    bram_insert = reg_out;
                    to_register = bram_out;
                end
            end
            ROUTE_COUNT_UP: begin
                array_cnt_out = array_cnt_in + 1'b1;
            end
            ROUTE_SHIFT: begin
                // Stored key moves down one slot unchanged
                bram_insert = bram_out;
                // Head key held in the carried register
                data_lt_o   = reg_out;
            end
            ROUTE_COUNT_DOWN: begin
                array_cnt_out = array_cnt_in - 1'b1;
            end
            default: begin
                // Idle, defaults only
            end
        endcase

        // Flags follow the stepped count
        full  = (array_cnt_out == array_size);
        empty = (array_cnt_out == '0);

        // Both flags high means a broken count or a zero size
        assert (!(full && empty))
            else $error("value_router: full and empty both high");
    end

endmodule

// ==== hdl/queue_bram.sv ====
`timescale 1ns/100ps
`include "pq_defs.svh"

module queue_bram (
    input  logic                  clk,
    input  logic [`PQ_ADDR_W-1:0] addr,
    input  logic                  we,
    input  logic [`PQ_DATA_W-1:0] wdata,
    output logic [`PQ_DATA_W-1:0] rdata
);

    //////////////////////////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////////////////////////

    // Slot 0 holds the largest key
    logic [`PQ_DATA_W-1:0] mem [`PQ_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, one cycle latency
    // Read-first on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

    // No contents until the controller's clear sweep has run

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Writes land inside the array
    a_addr_range : assert property (
        @(posedge clk) we |-> (addr < `PQ_DEPTH)
    ) else $error("queue_bram: write address out of range");

endmodule

// ==== hdl/queue_controller.sv ====
`timescale 1ns/100ps
`include "pq_defs.svh"

module queue_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  insert,
    input  logic [`PQ_DATA_W-1:0] insert_data,
    input  logic                  remove,
    input  logic [`PQ_DATA_W-1:0] bram_insert,
    input  logic [`PQ_DATA_W-1:0] to_register,
    input  logic [`PQ_DATA_W-1:0] data_lt_o,
    input  logic [`PQ_CNT_W-1:0]  array_cnt_out,
    input  logic                  result,
    input  logic                  full,
    input  logic                  empty,
    output pq_pkg::router_mode_t  mode,
    output logic [`PQ_DATA_W-1:0] reg_out,
    output logic [`PQ_CNT_W-1:0]  array_size,
    output logic [`PQ_CNT_W-1:0]  array_cnt_in,
    output logic [`PQ_ADDR_W-1:0] addr,
    output logic                  we,
    output logic [`PQ_DATA_W-1:0] wdata,
    output logic                  busy,
    output logic [`PQ_DATA_W-1:0] data_out,
    output logic                  data_valid,
    output logic                  full_flag,
    output logic                  empty_flag
);

    import pq_pkg::*;

    // One extra pointer bit so the sweep can reach the depth
    localparam int                   PTR_W     = `PQ_ADDR_W + 1;
    localparam logic [PTR_W-1:0]     DEPTH_PTR = PTR_W'(`PQ_DEPTH);
    localparam logic [`PQ_CNT_W-1:0] DEPTH_CNT = `PQ_CNT_W'(`PQ_DEPTH);

    ctrl_state_t       state;
    ctrl_state_t       state_next;
    logic [PTR_W-1:0]  ptr;
    logic [PTR_W-1:0]  ptr_m1;
    logic [PTR_W-1:0]  cnt_ptr;
    logic [PTR_W-1:0]  cnt_m1;

    // Element count register
    logic [`PQ_CNT_W-1:0] cnt_q;

    assign array_size   = DEPTH_CNT;
    assign array_cnt_in = cnt_q;
    assign cnt_ptr      = cnt_q[PTR_W-1:0];
    assign ptr_m1       = ptr - 1'b1;
    assign cnt_m1       = cnt_ptr - 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Insert takes priority over remove
                if (insert) begin
                    if (!full_flag) state_next = INS_READ;
                end else if (remove && !empty_flag) begin
                    state_next = REM_READ;
                end
            end
            CLEAR:     if (ptr == DEPTH_PTR) state_next = IDLE;
            INS_READ:  state_next = INS_WRITE;
            // Walk ends on the slot at the old count
            INS_WRITE: state_next = (ptr == cnt_ptr) ? INS_COUNT : INS_READ;
            INS_COUNT: state_next = IDLE;
            // Nothing left to shift once the pointer reaches the count
            REM_READ:  state_next = (ptr == cnt_ptr) ? REM_COUNT : REM_WRITE;
            REM_WRITE: state_next = REM_READ;
            REM_COUNT: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= CLEAR;
            busy       <= 1'b0;
            ptr        <= '0;
            cnt_q      <= '0;
            full_flag  <= 1'b0;
            empty_flag <= 1'b1;
            data_valid <= 1'b0;
        end else begin
            state      <= state_next;
            busy       <= (state_next != IDLE);
            data_valid <= 1'b0;
            case (state)
                IDLE: ptr <= '0;
                CLEAR: begin
                    ptr <= ptr + 1'b1;
                    if (ptr == DEPTH_PTR) begin
                        cnt_q      <= '0;
                        full_flag  <= 1'b0;
                        empty_flag <= 1'b1;
                    end
                end
                INS_WRITE: ptr <= ptr + 1'b1;
                INS_COUNT, REM_COUNT: begin
                    cnt_q      <= array_cnt_out;
                    full_flag  <= full;
                    empty_flag <= empty;
                end
                // Head key already in the carried register
                REM_READ:  if (ptr == PTR_W'(1)) data_valid <= 1'b1;
                REM_WRITE: ptr <= ptr + 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Carried key and output key
    always_ff @(posedge clk) begin
        if (state == IDLE && insert && !full_flag) reg_out <= insert_data;
        if (state == INS_WRITE) reg_out <= to_register;
        if (state == REM_WRITE && ptr == '0) reg_out <= bram_insert;
        if (state == REM_READ && ptr == PTR_W'(1)) data_out <= data_lt_o;
    end

    //////////////////////////////////////////////////////////////////////
    // Router mode and RAM port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mode  = ROUTE_IDLE;
        addr  = ptr[`PQ_ADDR_W-1:0];
        we    = 1'b0;
        wdata = bram_insert;
        case (state)
            CLEAR: begin
                we    = (ptr != DEPTH_PTR);
                wdata = `PQ_EMPTY_SLOT;
            end
            INS_WRITE: begin
                mode = ROUTE_COMPARE;
                we   = 1'b1;
            end
            INS_COUNT: mode = ROUTE_COUNT_UP;
            REM_READ:  mode = ROUTE_SHIFT;
            REM_WRITE: begin
                // Key read from ptr goes one slot down
                mode = ROUTE_SHIFT;
                we   = (ptr != '0);
                addr = ptr_m1[`PQ_ADDR_W-1:0];
            end
            REM_COUNT: begin
                // Freed last slot becomes empty
                mode  = ROUTE_COUNT_DOWN;
                we    = 1'b1;
                addr  = cnt_m1[`PQ_ADDR_W-1:0];
                wdata = `PQ_EMPTY_SLOT;
            end
            default: begin
            end
        endcase
    end

    // No RAM writes while waiting for a command
    a_idle_no_we : assert property (
        @(posedge clk) disable iff (reset) (state == IDLE) |-> !we
    ) else $error("queue_controller: write in IDLE");

    // Output pulse only right after the head read
    a_valid_in_remove : assert property (
        @(posedge clk) disable iff (reset) data_valid |-> (state inside {REM_WRITE, REM_COUNT})
    ) else $error("queue_controller: data_valid outside a remove");

    // Slot at the old count is empty, so the carried key must land there
    a_last_slot_takes : assert property (
        @(posedge clk) disable iff (reset) (state == INS_WRITE && ptr == cnt_ptr) |-> result
    ) else $error("queue_controller: carried key lost at end of insert walk");

endmodule

// ==== hdl/priority_queue_top.sv ====
`timescale 1ns/100ps
`include "pq_defs.svh"

module priority_queue_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  insert,
    input  logic [`PQ_DATA_W-1:0] insert_data,
    input  logic                  remove,
    output logic                  busy,
    output logic                  full,
    output logic                  empty,
    output logic [`PQ_DATA_W-1:0] data_out,
    output logic                  data_valid
);

    import pq_pkg::*;

    // Controller to router
    router_mode_t          mode;
    logic [`PQ_DATA_W-1:0] reg_out;
    logic [`PQ_CNT_W-1:0]  array_size;
    logic [`PQ_CNT_W-1:0]  array_cnt_in;

    // Router back to controller
    logic [`PQ_DATA_W-1:0] bram_insert;
    logic [`PQ_DATA_W-1:0] to_register;
    logic [`PQ_DATA_W-1:0] data_lt_o;
    logic [`PQ_CNT_W-1:0]  array_cnt_out;
    logic                  result;
    logic                  router_full;
    logic                  router_empty;

    // RAM port
    logic [`PQ_ADDR_W-1:0] addr;
    logic                  we;
    logic [`PQ_DATA_W-1:0] wdata;
    logic [`PQ_DATA_W-1:0] bram_out;

    //////////////////////////////////////////////////////////////////////
    // Sequencer, datapath and storage
    //////////////////////////////////////////////////////////////////////

    queue_controller u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .insert        (insert),
        .insert_data   (insert_data),
        .remove        (remove),
        .bram_insert   (bram_insert),
        .to_register   (to_register),
        .data_lt_o     (data_lt_o),
        .array_cnt_out (array_cnt_out),
        .result        (result),
        .full          (router_full),
        .empty         (router_empty),
        .mode          (mode),
        .reg_out       (reg_out),
        .array_size    (array_size),
        .array_cnt_in  (array_cnt_in),
        .addr          (addr),
        .we            (we),
        .wdata         (wdata),
        .busy          (busy),
        .data_out      (data_out),
        .data_valid    (data_valid),
        .full_flag     (full),
        .empty_flag    (empty)
    );

    value_router u_router (
        .bram_out      (bram_out),
        .reg_out       (reg_out),
        .mode          (mode),
        .array_size    (array_size),
        .array_cnt_in  (array_cnt_in),
        .bram_insert   (bram_insert),
        .to_register   (to_register),
        .data_lt_o     (data_lt_o),
        .array_cnt_out (array_cnt_out),
        .result        (result),
        .full          (router_full),
        .empty         (router_empty)
    );

    queue_bram u_bram (
        .clk   (clk),
        .addr  (addr),
        .we    (we),
        .wdata (wdata),
        .rdata (bram_out)
    );

endmodule

// ==== testbench/tb_pq_tasks.svh ====
`ifndef TB_PQ_TASKS_SVH
`define TB_PQ_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Checking and reporting
//////////////////////////////////////////////////////////////////////

task automatic check_equal(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("** Error at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

// One line per finished test
task automatic report_test(input string name);
    $display("%s: %s, %0d failed checks", name,
             (fail_count == test_fail_base) ? "ok" : "failed", fail_count - test_fail_base);
    test_fail_base = fail_count;
endtask

// Idle DUT, flags follow the model count
task automatic check_flags(input string what);
    check_equal({what, ": busy"}, 0, 32'(busy));
    check_equal({what, ": full"}, 32'(model_q.size() == `PQ_DEPTH), 32'(full));
    check_equal({what, ": empty"}, 32'(model_q.size() == 0), 32'(empty));
endtask

//////////////////////////////////////////////////////////////////////
// Random keys
//////////////////////////////////////////////////////////////////////

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic feedback;
    feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], feedback};
endfunction

// One step per bit, newest bit lands at the bottom
task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value      = {value[30:0], lfsr_state[0]};
    end
endtask

//////////////////////////////////////////////////////////////////////
// Bounded waits, all sampled on the falling edge
//////////////////////////////////////////////////////////////////////

// Also counts data_valid pulses seen on the way
task automatic wait_for_idle(input string what, output int pulses);
    int cycles;
    cycles = 0;
    pulses = 0;
    while (busy && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        if (data_valid) pulses++;
        cycles++;
    end
    if (busy) begin
        $display("Timeout: busy still high after %0d cycles of %s", WAIT_LIMIT, what);
        fail_count++;
    end
endtask

task automatic wait_for_valid(input string what, output logic seen);
    int cycles;
    cycles = 0;
    while (!data_valid && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    seen = data_valid;
    if (!seen) begin
        $display("Timeout: no data_valid pulse within %0d cycles of %s", WAIT_LIMIT, what);
        fail_count++;
    end
endtask

// Refused command, DUT must stay quiet for a few cycles
task automatic check_quiet(input string what);
    int active;
    active = 0;
    repeat (4) begin
        if (busy || data_valid) active++;
        @(negedge clk);
    end
    check_equal({what, ": cycles with activity"}, 0, active);
endtask

`endif

// ==== testbench/tb_priority_queue.sv ====
`timescale 1ns/100ps
`include "pq_defs.svh"

module tb_priority_queue;

    // Cycle bound for any single wait
    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  reset;
    logic                  insert;
    logic [`PQ_DATA_W-1:0] insert_data;
    logic                  remove;
    logic                  busy;
    logic                  full;
    logic                  empty;
    logic [`PQ_DATA_W-1:0] data_out;
    logic                  data_valid;

    // Reference model, largest key at the front
    logic [`PQ_DATA_W-1:0] model_q [$];

    int          pass_count;
    int          fail_count;
    int          test_fail_base;
    logic [15:0] lfsr_state;

    priority_queue_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .insert      (insert),
        .insert_data (insert_data),
        .remove      (remove),
        .busy        (busy),
        .full        (full),
        .empty       (empty),
        .data_out    (data_out),
        .data_valid  (data_valid)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    `include "tb_pq_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Model and command helpers
    //////////////////////////////////////////////////////////////////////

    // Equal keys go behind the ones already stored
    task automatic model_add(input logic [31:0] key);
        int pos;
        pos = 0;
        while (pos < model_q.size() && model_q[pos] >= key) pos++;
        model_q.insert(pos, key);
    endtask

    task automatic insert_key(input logic [31:0] key);
        logic accept;
        int   pulses;
        accept      = !busy && (model_q.size() < `PQ_DEPTH);
        insert      = 1'b1;
        insert_data = key;
        @(negedge clk);
        insert = 1'b0;
        if (accept) begin
            check_equal("busy after insert", 1, 32'(busy));
            model_add(key);
            wait_for_idle("insert", pulses);
            check_equal("data_valid during insert", 0, pulses);
        end else begin
            check_quiet("refused insert");
        end
        check_flags("insert");
    endtask

    task automatic remove_key(input string what);
        logic        accept;
        logic        seen;
        logic [31:0] expected;
        logic [31:0] held;
        int          pulses;
        accept = !busy && (model_q.size() > 0);
        held   = data_out;
        remove = 1'b1;
        @(negedge clk);
        remove = 1'b0;
        if (accept) begin
            // Head of the model is the largest key
            expected = model_q.pop_front();
            check_equal({what, ": busy"}, 1, 32'(busy));
            wait_for_valid(what, seen);
            if (seen) check_equal({what, ": data_out"}, expected, data_out);
            wait_for_idle(what, pulses);
            check_equal({what, ": extra data_valid"}, 0, pulses);
        end else begin
            check_quiet(what);
            check_equal({what, ": data_out held"}, held, data_out);
        end
        check_flags(what);
    endtask

    task automatic fill_queue();
        logic [31:0] key;
        while (model_q.size() < `PQ_DEPTH) begin
            // 31 bits, so never the sentinel
            random_bits(31, key);
            insert_key(key);
        end
    endtask

    task automatic drain_queue(input string what);
        while (model_q.size() > 0) remove_key(what);
    endtask

    // Strobe insert then remove while the DUT is busy
    task automatic strobe_while_busy();
        check_equal("busy before stray insert", 1, 32'(busy));
        remove      = 1'b0;
        insert      = 1'b1;
        insert_data = 32'd999;
        @(negedge clk);
        insert = 1'b0;
        check_equal("busy before stray remove", 1, 32'(busy));
        remove = 1'b1;
        @(negedge clk);
        remove = 1'b0;
    endtask

    // Strobe held for three cycles that the DUT must refuse
    task automatic hold_refused(input string what, input logic is_insert);
        int          active;
        logic [31:0] held;
        active      = 0;
        held        = data_out;
        insert      = is_insert;
        remove      = !is_insert;
        insert_data = 32'h1234;
        repeat (3) begin
            @(negedge clk);
            if (busy || data_valid) active++;
        end
        insert = 1'b0;
        remove = 1'b0;
        check_equal({what, ": active while held"}, 0, active);
        check_quiet(what);
        check_equal({what, ": data_out held"}, held, data_out);
        check_flags(what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_flags("after clear sweep");
        remove_key("remove after reset");
        report_test("reset and clear sweep");
    endtask

    task automatic test_ordered_keys();
        logic [31:0] keys [5];
        keys = '{32'd5, 32'd40, 32'd12, 32'd40, 32'd0};
        foreach (keys[i]) insert_key(keys[i]);
        // Expect 40, 40, 12, 5, 0
        repeat (5) remove_key("ordered remove");
        check_equal("empty after ordered drain", 1, 32'(empty));
        report_test("ordered keys");
    endtask

    task automatic test_fill_drain();
        logic [31:0] key;
        fill_queue();
        check_equal("full after fill", 1, 32'(full));
        random_bits(31, key);
        insert_key(key);
        repeat (`PQ_DEPTH) remove_key("drain full queue");
        // One past the depth, nothing left
        remove_key("remove past depth");
        report_test("fill and drain");
    endtask

    task automatic test_busy_strobes();
        logic        seen;
        logic [31:0] expected;
        int          pulses;
        insert_key(32'd300);
        insert_key(32'd100);
        insert_key(32'd200);
        // Stray strobes during an insert walk
        insert      = 1'b1;
        insert_data = 32'd150;
        @(negedge clk);
        model_add(32'd150);
        strobe_while_busy();
        wait_for_idle("insert with stray strobes", pulses);
        check_flags("insert with stray strobes");
        // Stray strobes during a remove shift
        expected = model_q.pop_front();
        insert   = 1'b0;
        remove   = 1'b1;
        @(negedge clk);
        strobe_while_busy();
        wait_for_valid("remove with stray strobes", seen);
        check_equal("head with stray strobes", expected, data_out);
        wait_for_idle("remove with stray strobes", pulses);
        check_flags("remove with stray strobes");
        drain_queue("drain after stray strobes");
        report_test("strobes while busy");
    endtask

    task automatic test_random_ops();
        logic [31:0] pick;
        logic [31:0] key;
        for (int n = 0; n < 200; n++) begin
            random_bits(1, pick);
            if (pick[0]) begin
                random_bits(31, key);
                insert_key(key);
            end else begin
                remove_key("random remove");
            end
        end
        drain_queue("random drain");
        report_test("random operations");
    endtask

    task automatic test_refused_commands();
        hold_refused("remove while empty", 1'b0);
        fill_queue();
        hold_refused("insert while full", 1'b1);
        drain_queue("drain after full");
        hold_refused("remove while empty again", 1'b0);
        report_test("refused commands");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int pulses;
        clk            = 1'b0;
        reset          = 1'b1;
        insert         = 1'b0;
        remove         = 1'b0;
        insert_data    = '0;
        pass_count     = 0;
        fail_count     = 0;
        test_fail_base = 0;
        lfsr_state     = 16'd39;

        // Reset held for 8 cycles
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_equal("busy during clear sweep", 1, 32'(busy));
        wait_for_idle("clear sweep", pulses);
        check_equal("data_valid during clear sweep", 0, pulses);

        test_reset_state();
        test_ordered_keys();
        test_fill_drain();
        test_busy_strobes();
        test_random_ops();
        test_refused_commands();

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
+incdir+testbench
hdl/pq_pkg.sv
hdl/value_router.sv
hdl/queue_bram.sv
hdl/queue_controller.sv
hdl/priority_queue_top.sv
testbench/tb_priority_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_priority_queue
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
